// File: design/dma_defines.svh
`ifndef DMA_DEFINES_SVH
`define DMA_DEFINES_SVH

// ------------------------------
// Bus geometry
// ------------------------------
// Byte address width
`define DMA_ADDR_W 16
// Wishbone data width
`define DMA_DATA_W 32
// Byte selects per word
`define DMA_STRB_W 4

// ------------------------------
// Request and buffering
// ------------------------------
`define DMA_LEN_W 12
`define DMA_FIFO_DEPTH 8

`endif

// File: design/dma_pkg.sv
`include "dma_defines.svh"

package dma_pkg;

    // One word-bounded piece of a copy
    typedef struct packed {
        // Word-aligned address
        logic [`DMA_ADDR_W-1:0] addr;
        // First byte lane inside the word
        logic [1:0]             offset;
        // Bytes in this piece, 1 to 4
        logic [2:0]             count;
        // Final piece of the request
        logic                   last;
    } dma_piece_t;

    // Legalizer side
    typedef enum logic {
        LEG_IDLE,
        LEG_ACTIVE
    } leg_state_e;

    // Reader and writer FSM
    typedef enum logic [1:0] {
        PORT_IDLE,
        PORT_BUS,   // access open, waiting for ack
        PORT_MOVE   // bytes to or from the FIFO
    } port_state_e;

    // Shared bus owner
    typedef enum logic {
        OWN_READER,
        OWN_WRITER
    } arb_owner_e;

endpackage

// File: design/dma_bus_if.sv
`timescale 1ns/100ps
`include "dma_defines.svh"

// Wishbone classic, single access per ack
interface dma_bus_if ();

    logic                   cyc;
    logic                   stb;
    logic                   we;
    logic [`DMA_ADDR_W-1:0] adr;
    logic [`DMA_DATA_W-1:0] dat_w;
    logic [`DMA_STRB_W-1:0] sel;
    // Slave side
    logic [`DMA_DATA_W-1:0] dat_r;
    logic                   ack;

    modport master (
        output cyc, stb, we, adr, dat_w, sel,
        input  dat_r, ack
    );

    modport slave (
        input  cyc, stb, we, adr, dat_w, sel,
        output dat_r, ack
    );

endinterface

// File: design/dma_piece_if.sv
`timescale 1ns/100ps

// Piece channel, transfer on valid and ready
interface dma_piece_if import dma_pkg::*; ();

    logic       valid;
    logic       ready;
    dma_piece_t piece;

    modport source (
        output valid, piece,
        input  ready
    );

    modport sink (
        input  valid, piece,
        output ready
    );

endinterface

// File: design/dma_legalizer.sv
`timescale 1ns/100ps
`include "dma_defines.svh"

module dma_legalizer import dma_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   req_valid_i,
    output logic                   req_ready_o,
    input  logic [`DMA_ADDR_W-1:0] src_addr_i,
    input  logic [`DMA_ADDR_W-1:0] dst_addr_i,
    input  logic [`DMA_LEN_W-1:0]  length_i,
    input  logic                   done_i,
    output logic                   busy_o,
    dma_piece_if.source            rd_piece_o,
    dma_piece_if.source            wr_piece_o
);

    localparam int AW = `DMA_ADDR_W;
    localparam int LW = `DMA_LEN_W;

    // Index 0 is the read side, index 1 the write side
    leg_state_e      state_q    [2];
    logic [AW-1:0]   addr_q     [2];
    logic [LW-1:0]   len_q      [2];
    logic [AW-1:0]   start_addr [2];
    dma_piece_t      side_piece [2];
    logic            side_valid [2];
    logic            side_ready [2];
    logic            outstanding_q;
    logic            accept;

    // Cut at the word boundary or at the end of the copy
    function automatic dma_piece_t make_piece(input logic [AW-1:0] addr,
                                              input logic [LW-1:0] len);
        dma_piece_t p;
        logic [2:0] room;
        room     = 3'd4 - {1'b0, addr[1:0]};
        p.addr   = {addr[AW-1:2], 2'b00};
        p.offset = addr[1:0];
        p.last   = (len <= LW'(room));
        p.count  = p.last ? len[2:0] : room;
        return p;
    endfunction

    // ------------------------------
    // Request handshake
    // ------------------------------
    // New copy only once both sides drained and done seen
    assign req_ready_o = (state_q[0] == LEG_IDLE) && (state_q[1] == LEG_IDLE)
                         && !outstanding_q;
    assign accept      = req_valid_i && req_ready_o;
    assign busy_o      = outstanding_q;

    assign start_addr[0] = src_addr_i;
    assign start_addr[1] = dst_addr_i;

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            side_piece[s] = make_piece(addr_q[s], len_q[s]);
            side_valid[s] = (state_q[s] == LEG_ACTIVE);
        end
    end

    // Channel mapping
    assign rd_piece_o.valid = side_valid[0];
    assign rd_piece_o.piece = side_piece[0];
    assign side_ready[0]    = rd_piece_o.ready;
    assign wr_piece_o.valid = side_valid[1];
    assign wr_piece_o.piece = side_piece[1];
    assign side_ready[1]    = wr_piece_o.ready;

    // ------------------------------
    // Side state
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            outstanding_q <= 1'b0;
            for (int s = 0; s < 2; s++) begin
                state_q[s] <= LEG_IDLE;
            end
        end else begin
            if (accept) begin
                outstanding_q <= 1'b1;
            end else if (done_i) begin
                outstanding_q <= 1'b0;
            end
            for (int s = 0; s < 2; s++) begin
                if (accept) begin
                    state_q[s] <= LEG_ACTIVE;
                end else if (side_valid[s] && side_ready[s] && side_piece[s].last) begin
                    state_q[s] <= LEG_IDLE;
                end
            end
        end
    end

    // Address and remaining length walk one piece per transfer
    always_ff @(posedge clk_i) begin
        for (int s = 0; s < 2; s++) begin
            if (accept) begin
                addr_q[s] <= start_addr[s];
                len_q[s]  <= length_i;
            end else if (side_valid[s] && side_ready[s]) begin
                addr_q[s] <= addr_q[s] + AW'(side_piece[s].count);
                len_q[s]  <= len_q[s] - LW'(side_piece[s].count);
            end
        end
    end

    // ------------------------------
    // Assertions
    // ------------------------------
    for (genvar s = 0; s < 2; s++) begin : g_hold
        assert property (@(posedge clk_i) disable iff (!rst_n_i)
            side_valid[s] && !side_ready[s] |=> side_valid[s] && $stable(side_piece[s]));
    end

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        accept |-> length_i != '0);

endmodule

// File: design/dma_reader.sv
`timescale 1ns/100ps
`include "dma_defines.svh"

module dma_reader import dma_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    dma_piece_if.sink  piece_i,
    dma_bus_if.master  bus_o,
    output logic       push_o,
    output logic [7:0] push_data_o,
    input  logic       full_i
);

    port_state_e            state_q;
    dma_piece_t             piece_q;
    logic [`DMA_DATA_W-1:0] word_q;
    // Current lane and bytes still to push
    logic [1:0]             lane_q;
    logic [2:0]             left_q;

    assign piece_i.ready = (state_q == PORT_IDLE);

    // Whole-word read, lanes picked later
    assign bus_o.cyc   = (state_q == PORT_BUS);
    assign bus_o.stb   = (state_q == PORT_BUS);
    assign bus_o.we    = 1'b0;
    assign bus_o.adr   = piece_q.addr;
    assign bus_o.dat_w = '0;
    assign bus_o.sel   = '1;

    assign push_o      = (state_q == PORT_MOVE) && !full_i;
    assign push_data_o = word_q[{lane_q, 3'b000} +: 8];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= PORT_IDLE;
        end else begin
            case (state_q)
                PORT_IDLE: begin
                    if (piece_i.valid) begin
                        state_q <= PORT_BUS;
                    end
                end
                PORT_BUS: begin
                    if (bus_o.ack) begin
                        state_q <= PORT_MOVE;
                    end
                end
                PORT_MOVE: begin
                    // Final byte of the piece
                    if (push_o && left_q == 3'd1) begin
                        state_q <= PORT_IDLE;
                    end
                end
                default: state_q <= PORT_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (piece_i.valid && piece_i.ready) begin
            piece_q <= piece_i.piece;
        end
        if (state_q == PORT_BUS && bus_o.ack) begin
            word_q <= bus_o.dat_r;
            lane_q <= piece_q.offset;
            left_q <= piece_q.count;
        end else if (push_o) begin
            lane_q <= lane_q + 2'd1;
            left_q <= left_q - 3'd1;
        end
    end

endmodule

// File: design/dma_writer.sv
`timescale 1ns/100ps
`include "dma_defines.svh"

module dma_writer import dma_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    dma_piece_if.sink  piece_i,
    dma_bus_if.master  bus_o,
    output logic       pop_o,
    input  logic [7:0] pop_data_i,
    input  logic       empty_i,
    output logic       done_o
);

    port_state_e            state_q;
    dma_piece_t             piece_q;
    logic [`DMA_DATA_W-1:0] data_q;
    logic [`DMA_STRB_W-1:0] sel_q;
    logic [1:0]             lane_q;
    logic [2:0]             left_q;
    logic                   done_q;

    assign piece_i.ready = (state_q == PORT_IDLE);
    assign pop_o         = (state_q == PORT_MOVE) && !empty_i;

    // Write carries only the lanes filled from the FIFO
    assign bus_o.cyc   = (state_q == PORT_BUS);
    assign bus_o.stb   = (state_q == PORT_BUS);
    assign bus_o.we    = 1'b1;
    assign bus_o.adr   = piece_q.addr;
    assign bus_o.dat_w = data_q;
    assign bus_o.sel   = sel_q;

    assign done_o = done_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= PORT_IDLE;
            done_q  <= 1'b0;
        end else begin
            // One-cycle pulse after the ack of the final write
            done_q <= (state_q == PORT_BUS) && bus_o.ack && piece_q.last;
            case (state_q)
                PORT_IDLE: begin
                    if (piece_i.valid) begin
                        state_q <= PORT_MOVE;
                    end
                end
                PORT_MOVE: begin
                    if (pop_o && left_q == 3'd1) begin
                        state_q <= PORT_BUS;
                    end
                end
                PORT_BUS: begin
                    if (bus_o.ack) begin
                        state_q <= PORT_IDLE;
                    end
                end
                default: state_q <= PORT_IDLE;
            endcase
        end
    end

    // Lane packing
    always_ff @(posedge clk_i) begin
        if (piece_i.valid && piece_i.ready) begin
            piece_q <= piece_i.piece;
            lane_q  <= piece_i.piece.offset;
            left_q  <= piece_i.piece.count;
            sel_q   <= '0;
        end else if (pop_o) begin
            data_q[{lane_q, 3'b000} +: 8] <= pop_data_i;
            sel_q[lane_q]                 <= 1'b1;
            lane_q                        <= lane_q + 2'd1;
            left_q                        <= left_q - 3'd1;
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        bus_o.stb |-> bus_o.sel != '0);

endmodule

// File: design/dma_byte_fifo.sv
`timescale 1ns/100ps
`include "dma_defines.svh"

module dma_byte_fifo (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       push_i,
    input  logic [7:0] push_data_i,
    output logic       full_o,
    input  logic       pop_i,
    output logic [7:0] pop_data_o,
    output logic       empty_o
);

    localparam int DEPTH = `DMA_FIFO_DEPTH;
    localparam int PW    = $clog2(DEPTH);

    logic [7:0]  mem_q [DEPTH];
    logic [PW-1:0] wr_ptr_q;
    logic [PW-1:0] rd_ptr_q;
    logic [PW:0]   count_q;

    assign full_o     = (count_q == (PW + 1)'(DEPTH));
    assign empty_o    = (count_q == '0);
    // First-word fall-through
    assign pop_data_o = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // Occupancy, unchanged on simultaneous push and pop
            if (push_i && !pop_i) begin
                count_q <= count_q + 1'b1;
            end else if (pop_i && !push_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_n_i) push_i |-> !full_o);
    assert property (@(posedge clk_i) disable iff (!rst_n_i) pop_i |-> !empty_o);

endmodule

// File: design/dma_bus_arbiter.sv
`timescale 1ns/100ps

module dma_bus_arbiter import dma_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    dma_bus_if.slave  rd_bus_i,
    dma_bus_if.slave  wr_bus_i,
    dma_bus_if.master mem_bus_o
);

    arb_owner_e owner_q;
    arb_owner_e next_owner;
    logic       locked_q;
    logic       rd_req;
    logic       wr_req;
    logic       own_rd;

    assign rd_req = rd_bus_i.cyc && rd_bus_i.stb;
    assign wr_req = wr_bus_i.cyc && wr_bus_i.stb;
    assign own_rd = (owner_q == OWN_READER);

    // Other side first, else the last owner again
    always_comb begin
        next_owner = owner_q;
        if (own_rd) begin
            if (wr_req) begin
                next_owner = OWN_WRITER;
            end
        end else if (rd_req) begin
            next_owner = OWN_READER;
        end
    end

    // ------------------------------
    // Grant and release
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            owner_q  <= OWN_READER;
            locked_q <= 1'b0;
        end else if (!locked_q) begin
            if (rd_req || wr_req) begin
                owner_q  <= next_owner;
                locked_q <= 1'b1;
            end
        end else if (mem_bus_o.ack) begin
            locked_q <= 1'b0;
        end
    end

    // Owner's master signals onto the memory bus
    assign mem_bus_o.cyc   = locked_q && (own_rd ? rd_bus_i.cyc : wr_bus_i.cyc);
    assign mem_bus_o.stb   = locked_q && (own_rd ? rd_bus_i.stb : wr_bus_i.stb);
    assign mem_bus_o.we    = own_rd ? rd_bus_i.we    : wr_bus_i.we;
    assign mem_bus_o.adr   = own_rd ? rd_bus_i.adr   : wr_bus_i.adr;
    assign mem_bus_o.dat_w = own_rd ? rd_bus_i.dat_w : wr_bus_i.dat_w;
    assign mem_bus_o.sel   = own_rd ? rd_bus_i.sel   : wr_bus_i.sel;

    // Ack and read data back to the owner only
    assign rd_bus_i.ack   = locked_q && own_rd && mem_bus_o.ack;
    assign wr_bus_i.ack   = locked_q && !own_rd && mem_bus_o.ack;
    assign rd_bus_i.dat_r = own_rd ? mem_bus_o.dat_r : '0;
    assign wr_bus_i.dat_r = own_rd ? '0 : mem_bus_o.dat_r;

    // Open cycle keeps its owner and stays open until ack
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_bus_o.cyc && !mem_bus_o.ack |=> $stable(owner_q) && mem_bus_o.cyc);

endmodule

// File: design/dma_top.sv
`timescale 1ns/100ps
`include "dma_defines.svh"

module dma_top (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    // Copy request
    input  logic                   req_valid_i,
    output logic                   req_ready_o,
    input  logic [`DMA_ADDR_W-1:0] src_addr_i,
    input  logic [`DMA_ADDR_W-1:0] dst_addr_i,
    input  logic [`DMA_LEN_W-1:0]  length_i,
    output logic                   busy_o,
    output logic                   done_o,
    // Wishbone master
    output logic                   wb_cyc_o,
    output logic                   wb_stb_o,
    output logic                   wb_we_o,
    output logic [`DMA_ADDR_W-1:0] wb_adr_o,
    output logic [`DMA_DATA_W-1:0] wb_dat_o,
    output logic [`DMA_STRB_W-1:0] wb_sel_o,
    input  logic [`DMA_DATA_W-1:0] wb_dat_i,
    input  logic                   wb_ack_i
);

    dma_piece_if rd_piece ();
    dma_piece_if wr_piece ();
    dma_bus_if   rd_bus ();
    dma_bus_if   wr_bus ();
    dma_bus_if   mem_bus ();

    logic       push;
    logic [7:0] push_data;
    logic       full;
    logic       pop;
    logic [7:0] pop_data;
    logic       empty;

    dma_legalizer u_legalizer (
        .clk_i, .rst_n_i, .req_valid_i, .req_ready_o,
        .src_addr_i, .dst_addr_i, .length_i,
        .done_i     (done_o),
        .busy_o,
        .rd_piece_o (rd_piece),
        .wr_piece_o (wr_piece)
    );

    dma_reader u_reader (
        .clk_i, .rst_n_i,
        .piece_i (rd_piece), .bus_o (rd_bus),
        .push_o (push), .push_data_o (push_data), .full_i (full)
    );

    dma_byte_fifo u_fifo (
        .clk_i, .rst_n_i,
        .push_i (push), .push_data_i (push_data), .full_o (full),
        .pop_i (pop), .pop_data_o (pop_data), .empty_o (empty)
    );

    dma_writer u_writer (
        .clk_i, .rst_n_i,
        .piece_i (wr_piece), .bus_o (wr_bus),
        .pop_o (pop), .pop_data_i (pop_data), .empty_i (empty),
        .done_o
    );

    dma_bus_arbiter u_arbiter (
        .clk_i, .rst_n_i,
        .rd_bus_i (rd_bus), .wr_bus_i (wr_bus), .mem_bus_o (mem_bus)
    );

    // Shared master out to the pins
    assign wb_cyc_o      = mem_bus.cyc;
    assign wb_stb_o      = mem_bus.stb;
    assign wb_we_o       = mem_bus.we;
    assign wb_adr_o      = mem_bus.adr;
    assign wb_dat_o      = mem_bus.dat_w;
    assign wb_sel_o      = mem_bus.sel;
    assign mem_bus.dat_r = wb_dat_i;
    assign mem_bus.ack   = wb_ack_i;

endmodule

// File: sim/dma_checker.sv
`timescale 1ns/100ps
`include "dma_defines.svh"

module dma_checker (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   req_valid_i,
    input  logic                   req_ready_i,
    input  logic [`DMA_ADDR_W-1:0] src_addr_i,
    input  logic [`DMA_ADDR_W-1:0] dst_addr_i,
    input  logic [`DMA_LEN_W-1:0]  length_i,
    input  logic                   busy_i,
    input  logic                   done_i,
    input  logic                   wb_cyc_i,
    input  logic                   wb_stb_i,
    input  logic                   wb_we_i,
    input  logic [`DMA_ADDR_W-1:0] wb_adr_i,
    input  logic [`DMA_DATA_W-1:0] wb_wdata_i,
    input  logic [`DMA_STRB_W-1:0] wb_sel_i,
    input  logic                   wb_ack_i,
    output int                     tests_o,
    output int                     failures_o,
    output int                     errors_o
);

    localparam int AW = `DMA_ADDR_W;
    localparam int LW = `DMA_LEN_W;

    // Expected contents and contents as written on the bus
    logic [7:0]             ref_mem  [65536];
    logic [7:0]             seen_mem [65536];
    bit                     mem_loaded    = 1'b0;
    bit                     reset_checked = 1'b0;
    bit                     in_flight     = 1'b0;
    bit                     open_q        = 1'b0;
    logic [AW-1:0]          act_src;
    logic [AW-1:0]          act_dst;
    logic [LW-1:0]          act_len;
    logic                   prev_we;
    logic [AW-1:0]          prev_adr;
    logic [`DMA_DATA_W-1:0] prev_dat;
    logic [`DMA_STRB_W-1:0] prev_sel;
    int                     errors_base = 0;
    int                     tests       = 0;
    int                     failures    = 0;
    int                     errors      = 0;

    assign tests_o    = tests;
    assign failures_o = failures;
    assign errors_o   = errors;

    function automatic logic [7:0] fill_byte(input int unsigned a);
        return 8'(a ^ (a >> 8) ^ (a >> 5) ^ 32'h5a3c);
    endfunction

    // Non-empty single run of ones
    function automatic bit sel_contiguous(input logic [3:0] s);
        logic [3:0] v;
        v = s;
        if (v == 4'd0) return 1'b0;
        while (!v[0]) v = v >> 1;
        return ((v & (v + 4'd1)) == 4'd0);
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("mismatch %s: got %h expected %h", name, got, exp);
        errors++;
    endtask

    task automatic report_error(input string msg);
        $display("error: %s", msg);
        errors++;
    endtask

    task automatic expect_bit(input string name, input logic got, input logic exp);
        if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic end_test(input string what);
        tests++;
        if (errors != errors_base) failures++;
        $display("test %0d %s: %s", tests, what, (errors != errors_base) ? "fail" : "pass");
    endtask

    // ------------------------------
    // Request and done tracking
    // ------------------------------
    task automatic start_copy();
        act_src     = src_addr_i;
        act_dst     = dst_addr_i;
        act_len     = length_i;
        errors_base = errors;
        in_flight   = 1'b1;
        for (int i = 0; i < int'(length_i); i++) begin
            ref_mem[AW'(int'(dst_addr_i) + i)] = ref_mem[AW'(int'(src_addr_i) + i)];
        end
    endtask

    // Destination plus one guard byte on each side
    task automatic finish_copy();
        logic [AW-1:0] a;
        for (int i = -1; i <= int'(act_len); i++) begin
            a = AW'(int'(act_dst) + i);
            if (seen_mem[a] !== ref_mem[a]) begin
                report_mismatch($sformatf("mem[%h]", a), 32'(seen_mem[a]), 32'(ref_mem[a]));
            end
        end
        end_test($sformatf("copy %h to %h len %0d", act_src, act_dst, act_len));
        in_flight = 1'b0;
    endtask

    task automatic check_handshake();
        if (in_flight) begin
            expect_bit("busy_o", busy_i, 1'b1);
            expect_bit("req_ready_o", req_ready_i, 1'b0);
            if (done_i) finish_copy();
        end else begin
            expect_bit("busy_o", busy_i, 1'b0);
            if (done_i) report_error("done_o pulsed with no copy in progress");
            if (req_valid_i && req_ready_i) start_copy();
        end
    endtask

    // ------------------------------
    // Bus rules
    // ------------------------------
    task automatic check_write();
        logic [AW-1:0] a;
        logic [AW-1:0] off;
        if (!sel_contiguous(wb_sel_i)) begin
            report_error($sformatf("write select %h is empty or not one run", wb_sel_i));
        end
        if (!in_flight) report_error("bus write with no copy in progress");
        for (int b = 0; b < 4; b++) begin
            if (wb_sel_i[b]) begin
                a   = AW'(int'(wb_adr_i) + b);
                off = a - act_dst;
                if (off >= AW'(act_len)) begin
                    report_error($sformatf("write to %h outside the destination range", a));
                end
                seen_mem[a] = wb_wdata_i[8*b +: 8];
            end
        end
    endtask

    task automatic check_bus();
        if (wb_cyc_i && wb_stb_i) begin
            if (wb_adr_i[1:0] != 2'b00) report_mismatch("wb_adr_o[1:0]", 32'(wb_adr_i[1:0]), 0);
            // Held steady while waiting for ack
            if (open_q) begin
                if (wb_we_i !== prev_we) report_mismatch("wb_we_o", 32'(wb_we_i), 32'(prev_we));
                if (wb_adr_i !== prev_adr) report_mismatch("wb_adr_o", 32'(wb_adr_i), 32'(prev_adr));
                if (wb_wdata_i !== prev_dat) report_mismatch("wb_dat_o", wb_wdata_i, prev_dat);
                if (wb_sel_i !== prev_sel) report_mismatch("wb_sel_o", 32'(wb_sel_i), 32'(prev_sel));
            end
            if (wb_we_i && wb_ack_i) check_write();
            prev_we  = wb_we_i;
            prev_adr = wb_adr_i;
            prev_dat = wb_wdata_i;
            prev_sel = wb_sel_i;
            open_q   = !wb_ack_i;
        end else begin
            if (open_q) report_error("wb_stb_o dropped before ack");
            open_q = 1'b0;
        end
    endtask

    // Mid-cycle sampling, all values settled
    always @(negedge clk_i) begin
        if (!rst_n_i) begin
            if (!mem_loaded) begin
                for (int i = 0; i < 65536; i++) begin
                    ref_mem[i]  = fill_byte(i);
                    seen_mem[i] = fill_byte(i);
                end
                mem_loaded = 1'b1;
            end
            reset_checked = 1'b0;
            in_flight     = 1'b0;
            open_q        = 1'b0;
        end else begin
            if (!reset_checked) begin
                errors_base = errors;
                expect_bit("wb_cyc_o", wb_cyc_i, 1'b0);
                expect_bit("wb_stb_o", wb_stb_i, 1'b0);
                expect_bit("done_o", done_i, 1'b0);
                expect_bit("busy_o", busy_i, 1'b0);
                expect_bit("req_ready_o", req_ready_i, 1'b1);
                end_test("levels after reset");
                reset_checked = 1'b1;
            end
            check_bus();
            check_handshake();
        end
    end

endmodule

// File: sim/tb_dma_top.sv
`timescale 1ns/100ps
`include "dma_defines.svh"

module tb_dma_top;

    localparam int AW             = `DMA_ADDR_W;
    localparam int LW             = `DMA_LEN_W;
    localparam int TIMEOUT_CYCLES = 4000;

    logic                   clk;
    logic                   rst_n;
    logic                   req_valid;
    logic                   req_ready;
    logic [AW-1:0]          src_addr;
    logic [AW-1:0]          dst_addr;
    logic [LW-1:0]          length;
    logic                   busy;
    logic                   done;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    logic [AW-1:0]          wb_adr;
    logic [`DMA_DATA_W-1:0] wb_dat_w;
    logic [`DMA_STRB_W-1:0] wb_sel;
    logic [`DMA_DATA_W-1:0] wb_dat_r;
    logic                   wb_ack;

    // Memory model storage
    logic [7:0]  mem [65536];
    int          requests;
    int          tests;
    int          failures;
    int          errors;
    bit          timed_out;
    int unsigned seed_val;

    dma_top dut_i (
        .clk_i (clk), .rst_n_i (rst_n),
        .req_valid_i (req_valid), .req_ready_o (req_ready),
        .src_addr_i (src_addr), .dst_addr_i (dst_addr), .length_i (length),
        .busy_o (busy), .done_o (done),
        .wb_cyc_o (wb_cyc), .wb_stb_o (wb_stb), .wb_we_o (wb_we),
        .wb_adr_o (wb_adr), .wb_dat_o (wb_dat_w), .wb_sel_o (wb_sel),
        .wb_dat_i (wb_dat_r), .wb_ack_i (wb_ack)
    );

    dma_checker u_checker (
        .clk_i (clk), .rst_n_i (rst_n),
        .req_valid_i (req_valid), .req_ready_i (req_ready),
        .src_addr_i (src_addr), .dst_addr_i (dst_addr), .length_i (length),
        .busy_i (busy), .done_i (done),
        .wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb), .wb_we_i (wb_we),
        .wb_adr_i (wb_adr), .wb_wdata_i (wb_dat_w), .wb_sel_i (wb_sel),
        .wb_ack_i (wb_ack),
        .tests_o (tests), .failures_o (failures), .errors_o (errors)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Same start contents as the checker's reference
    function automatic logic [7:0] fill_byte(input int unsigned a);
        return 8'(a ^ (a >> 8) ^ (a >> 5) ^ 32'h5a3c);
    endfunction

    // ------------------------------
    // Wishbone slave, 0 to 3 wait cycles
    // ------------------------------
    initial begin
        int            wait_left;
        bit            in_access;
        logic [AW-1:0] a;
        wb_ack    = 1'b0;
        wb_dat_r  = '0;
        wait_left = 0;
        in_access = 1'b0;
        for (int i = 0; i < 65536; i++) begin
            mem[i] = fill_byte(i);
        end
        forever begin
            @(posedge clk);
            #10;
            if (wb_ack) begin
                // Ack taken at this edge
                wb_ack    = 1'b0;
                in_access = 1'b0;
            end else if (rst_n && wb_cyc && wb_stb) begin
                if (!in_access) begin
                    in_access = 1'b1;
                    wait_left = int'($urandom_range(3, 0));
                end
                if (wait_left == 0) begin
                    a = wb_adr;
                    for (int b = 0; b < 4; b++) begin
                        if (wb_we && wb_sel[b]) begin
                            mem[int'(a) + b] = wb_dat_w[8*b +: 8];
                        end
                        wb_dat_r[8*b +: 8] = mem[int'(a) + b];
                    end
                    wb_ack = 1'b1;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    // Random non-overlapping ranges, one low and one high region
    task automatic run_copy(input bit aligned);
        logic [AW-1:0] s;
        logic [AW-1:0] d;
        logic [AW-1:0] t;
        logic [LW-1:0] l;
        bit            ok;
        ok = 1'b0;
        l  = aligned ? LW'(4 * $urandom_range(16, 1)) : LW'($urandom_range(64, 1));
        s  = AW'(16'h1000 + $urandom_range(16'h0ef0, 0));
        d  = AW'(16'h8000 + $urandom_range(16'h0ef0, 0));
        if (aligned) begin
            s[1:0] = 2'b00;
            d[1:0] = 2'b00;
        end
        if ($urandom_range(1, 0) == 1) begin
            t = s;
            s = d;
            d = t;
        end
        // Start as soon as the DMA is ready
        for (int c = 0; c < TIMEOUT_CYCLES; c++) begin
            if (req_ready) begin
                ok = 1'b1;
                break;
            end
            @(posedge clk);
            #10;
        end
        if (!ok) begin
            $display("timeout: req_ready_o did not rise within %0d cycles", TIMEOUT_CYCLES);
            timed_out = 1'b1;
            return;
        end
        src_addr  = s;
        dst_addr  = d;
        length    = l;
        req_valid = 1'b1;
        @(posedge clk);
        #10;
        req_valid = 1'b0;
        requests++;
        ok = 1'b0;
        for (int c = 0; c < TIMEOUT_CYCLES; c++) begin
            @(posedge clk);
            #10;
            if (done) begin
                ok = 1'b1;
                break;
            end
        end
        if (!ok) begin
            $display("timeout: done_o did not pulse within %0d cycles", TIMEOUT_CYCLES);
            timed_out = 1'b1;
        end
    endtask

    initial begin
        seed_val  = $urandom(32'h3ecd_d7e6);
        rst_n     = 1'b0;
        req_valid = 1'b0;
        src_addr  = '0;
        dst_addr  = '0;
        length    = '0;
        requests  = 0;
        timed_out = 1'b0;
        repeat (8) @(posedge clk);
        #10;
        rst_n = 1'b1;
        @(posedge clk);
        #10;
        // Aligned, then unaligned, then back to back
        for (int t = 0; t < 8; t++) begin
            if (!timed_out) run_copy(1'b1);
        end
        for (int t = 0; t < 12; t++) begin
            if (!timed_out) run_copy(1'b0);
        end
        for (int t = 0; t < 40; t++) begin
            if (!timed_out) run_copy(1'($urandom_range(1, 0)));
        end
        repeat (3) @(posedge clk);
        $display("tests %0d, failed %0d, errors %0d", tests, failures, errors);
        if (timed_out || failures != 0 || errors != 0 || tests != requests + 1) begin
            if (tests != requests + 1) begin
                $display("error: %0d results seen for %0d requests", tests - 1, requests);
            end
            $display("TESTBENCH FAILED");
        end else begin
            $display("TESTBENCH PASSED");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+design
design/dma_pkg.sv
design/dma_bus_if.sv
design/dma_piece_if.sv
design/dma_legalizer.sv
design/dma_reader.sv
design/dma_writer.sv
design/dma_byte_fifo.sv
design/dma_bus_arbiter.sv
design/dma_top.sv
sim/dma_checker.sv
sim/tb_dma_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the DMA testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module tb_dma_top -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# Verdict comes from the log only
if grep -q "^TESTBENCH PASSED$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
